// File: src/dpe_cfg.svh
// dot product engine sizes
`ifndef DPE_CFG_SVH
`define DPE_CFG_SVH

// one input word per operand per beat
`define DPE_WORD_W 32

// lanes per beat in int8 mode
// int16 mode fills only the lower half
`define DPE_LANES 4

// operand width after sign extension
// also the int16 lane width
`define DPE_OPND_W 16

// full-precision lane product
`define DPE_PROD_W 32

// partial sums and final result, wraps mod 2^32
`define DPE_ACC_W 32

`endif

// File: src/dpe_pkg.sv
// dot product engine types
`include "dpe_cfg.svh"

package dpe_pkg;

    // per-beat word interpretation
    typedef enum logic {
        MODE_INT8  = 1'b0,
        MODE_INT16 = 1'b1
    } dpe_mode_e;

    // raw lane element types
    // named signed types so element selects keep their sign
    typedef logic signed [`DPE_WORD_W/`DPE_LANES-1:0] int8_t;
    typedef logic signed [`DPE_OPND_W-1:0]            int16_t;

    // one input word, two views of the same bits
    // lane 0 sits in the low bits in both views
    typedef union packed {
        int8_t  [`DPE_LANES-1:0]   b8;
        int16_t [`DPE_LANES/2-1:0] h16;
    } lane_word_u;

    // sign-extended operand, wide enough for either mode
    typedef logic signed [`DPE_OPND_W-1:0] opnd_t;

    // 16x16 signed product
    typedef logic signed [`DPE_PROD_W-1:0] prod_t;

    // partial sum and accumulated result
    typedef logic signed [`DPE_ACC_W-1:0] acc_t;

endpackage

// File: src/dpe_stage_if.sv
// pipeline stage links
`include "dpe_cfg.svh"

// input stage to multiply stage
interface operand_if;
    import dpe_pkg::*;

    // beat qualifier and end-of-vector mark
    logic  valid;
    logic  last;

    // decoded operand pairs, lane 0 first
    // payload is don't-care while valid is low
    opnd_t opa [`DPE_LANES];
    opnd_t opb [`DPE_LANES];

    // producer side
    modport src (
        output valid,
        output last,
        output opa,
        output opb
    );

    // consumer side
    modport dst (
        input valid,
        input last,
        input opa,
        input opb
    );
endinterface

// multiply stage to adder tree
interface product_if;
    import dpe_pkg::*;

    logic  valid;
    logic  last;

    // one product per lane
    prod_t prod [`DPE_LANES];

    modport src (
        output valid,
        output last,
        output prod
    );

    modport dst (
        input valid,
        input last,
        input prod
    );
endinterface

// File: src/dpe_input_stage.sv
// beat register and lane decode
`include "dpe_cfg.svh"

module dpe_input_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_valid,
    input  logic                  i_last,
    input  dpe_pkg::dpe_mode_e    i_mode,
    input  dpe_pkg::lane_word_u   i_dataa,
    input  dpe_pkg::lane_word_u   i_datab,
    operand_if.src                o_opnd
);
    import dpe_pkg::*;

    // decoded operands before the register
    opnd_t opa_d [`DPE_LANES];
    opnd_t opb_d [`DPE_LANES];

    // decode both words through the view chosen by the mode
    always_comb begin
        // int8: every lane is one byte, sign-extended
        // int16: start from zero, upper lanes stay zero
        for (int k = 0; k < `DPE_LANES; k++) begin
            if (i_mode == MODE_INT8) begin
                opa_d[k] = opnd_t'(i_dataa.b8[k]);
                opb_d[k] = opnd_t'(i_datab.b8[k]);
            end else begin
                opa_d[k] = '0;
                opb_d[k] = '0;
            end
        end
        // int16: lanes 0 and 1 take the halfwords as they are
        if (i_mode == MODE_INT16) begin
            for (int h = 0; h < `DPE_LANES/2; h++) begin
                opa_d[h] = i_dataa.h16[h];
                opb_d[h] = i_datab.h16[h];
            end
        end
    end

    // qualifier
    always_ff @(posedge clk) begin
        if (rst) begin
            o_opnd.valid <= 1'b0;
        end else begin
            o_opnd.valid <= i_valid;
        end
    end

    // payload, captured every cycle
    // last only matters alongside valid
    always_ff @(posedge clk) begin
        o_opnd.last <= i_last;
        for (int k = 0; k < `DPE_LANES; k++) begin
            o_opnd.opa[k] <= opa_d[k];
            o_opnd.opb[k] <= opb_d[k];
        end
    end

endmodule

// File: src/dpe_mult_stage.sv
// four-lane signed multiply
`include "dpe_cfg.svh"

module dpe_mult_stage (
    input  logic      clk,
    input  logic      rst,
    operand_if.dst    i_opnd,
    product_if.src    o_prod
);
    import dpe_pkg::*;

    // valid follows the operands by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            o_prod.valid <= 1'b0;
        end else begin
            o_prod.valid <= i_opnd.valid;
        end
    end

    // products registered in one step
    // operands widened to product width first so the
    // multiply is done signed at full precision
    always_ff @(posedge clk) begin
        o_prod.last <= i_opnd.last;
        for (int k = 0; k < `DPE_LANES; k++) begin
            o_prod.prod[k] <= prod_t'(i_opnd.opa[k]) * prod_t'(i_opnd.opb[k]);
        end
    end

    // largest magnitude is -32768 * -32768 = 2^30, fits signed 32

endmodule

// File: src/dpe_adder_tree.sv
// two-level registered adder tree
module dpe_adder_tree (
    input  logic          clk,
    input  logic          rst,
    product_if.dst        i_prod,
    output logic          o_valid,
    output logic          o_last,
    output dpe_pkg::acc_t o_sum
);
    import dpe_pkg::*;

    // level one pair sums
    // [0] lanes 0+1, [1] lanes 2+3
    acc_t pair_sum [2];

    // qualifier shift, one slot per level
    logic [1:0] valid_sr;
    logic [1:0] last_sr;

    // valid moves with the data, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= 2'b00;
        end else begin
            valid_sr <= {valid_sr[0], i_prod.valid};
        end
    end

    // data path, no reset needed
    always_ff @(posedge clk) begin
        // level one
        pair_sum[0] <= acc_t'(i_prod.prod[0]) + acc_t'(i_prod.prod[1]);
        pair_sum[1] <= acc_t'(i_prod.prod[2]) + acc_t'(i_prod.prod[3]);
        // level two, wraps like the accumulator
        o_sum <= pair_sum[0] + pair_sum[1];
        // last rides alongside valid
        last_sr <= {last_sr[0], i_prod.last};
    end

    // outputs from the second slot
    assign o_valid = valid_sr[1];
    assign o_last  = last_sr[1];

endmodule

// File: src/dpe_accumulator.sv
// cross-beat accumulator
module dpe_accumulator (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_valid,
    input  logic          i_last,
    input  dpe_pkg::acc_t i_sum,
    output logic          o_valid,
    output dpe_pkg::acc_t o_result
);
    import dpe_pkg::*;

    // running sum of the vector in progress
    acc_t acc_q;

    // total including the current beat
    acc_t acc_next;

    assign acc_next = acc_q + i_sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q    <= '0;
            o_valid  <= 1'b0;
            o_result <= '0;
        end else begin
            // single-cycle pulse by default
            o_valid <= 1'b0;
            if (i_valid) begin
                if (i_last) begin
                    // close the vector
                    o_result <= acc_next;
                    o_valid  <= 1'b1;
                    // next beat starts a fresh vector
                    acc_q    <= '0;
                end else begin
                    acc_q <= acc_next;
                end
            end
            // no valid beat: running sum holds
        end
    end

    // o_result keeps the last total between pulses

endmodule

// File: src/dpe_top.sv
// dot product engine top
`include "dpe_cfg.svh"

module dpe_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_valid,
    input  logic                   i_last,
    input  logic                   i_mode,
    input  logic [`DPE_WORD_W-1:0] i_dataa,
    input  logic [`DPE_WORD_W-1:0] i_datab,
    output logic                   o_valid,
    output logic [`DPE_ACC_W-1:0]  o_result
);
    import dpe_pkg::*;

    // stage links
    operand_if u_opnd_if ();
    product_if u_prod_if ();

    // adder tree to accumulator
    logic tree_valid;
    logic tree_last;
    acc_t tree_sum;

    // stage 1: register and decode
    // 0 = int8, 1 = int16
    dpe_input_stage u_input (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .i_last  (i_last),
        .i_mode  (dpe_mode_e'(i_mode)),
        .i_dataa (lane_word_u'(i_dataa)),
        .i_datab (lane_word_u'(i_datab)),
        .o_opnd  (u_opnd_if.src)
    );

    // stage 2: lane products
    dpe_mult_stage u_mult (
        .clk    (clk),
        .rst    (rst),
        .i_opnd (u_opnd_if.dst),
        .o_prod (u_prod_if.src)
    );

    // stages 3 and 4: reduction
    dpe_adder_tree u_tree (
        .clk     (clk),
        .rst     (rst),
        .i_prod  (u_prod_if.dst),
        .o_valid (tree_valid),
        .o_last  (tree_last),
        .o_sum   (tree_sum)
    );

    // stage 5: accumulate until last
    dpe_accumulator u_acc (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (tree_valid),
        .i_last   (tree_last),
        .i_sum    (tree_sum),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

endmodule

// File: sim/dpe_props.sv
// dot product engine port checks
`include "dpe_cfg.svh"

module dpe_props (
    input logic                  clk,
    input logic                  rst,
    input logic                  i_valid,
    input logic                  i_last,
    input logic                  o_valid,
    input logic [`DPE_ACC_W-1:0] o_result
);

    // no result out of reset
    a_quiet_in_reset: assert property (@(posedge clk) rst |=> !o_valid)
        else $error("o_valid high while rst was asserted");

    // pipeline is empty on the first cycle after reset
    a_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |=> !o_valid)
        else $error("o_valid high on the cycle after reset");

    // every result comes from a last beat five samples back
    a_result_from_last: assert property (
        @(posedge clk) disable iff (rst)
        o_valid |-> $past(i_valid && i_last, 5)
    ) else $error("o_valid without a last beat five cycles earlier");

    // result fully known when presented
    a_result_known: assert property (
        @(posedge clk) disable iff (rst)
        o_valid |-> !$isunknown(o_result)
    ) else $error("o_result has unknown bits while o_valid is high");

endmodule

bind dpe_top dpe_props u_props (
    .clk      (clk),
    .rst      (rst),
    .i_valid  (i_valid),
    .i_last   (i_last),
    .o_valid  (o_valid),
    .o_result (o_result)
);

// File: sim/dpe_tb.sv
// dot product engine testbench
`include "dpe_cfg.svh"

module dpe_tb;
    import dpe_pkg::*;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 5;
    localparam int RAND_CYCLES  = 80;
    // idle cycles after the queue empties, to catch stray results
    localparam int DRAIN_TAIL   = 4;
    // worst case per drain: pipeline latency plus the tail
    localparam int DRAIN_CYCLES = 10;

    // table row: valid, last, mode, word a, word b
    typedef struct packed {
        logic        valid;
        logic        last;
        logic        mode;
        logic [31:0] dataa;
        logic [31:0] datab;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   i_valid;
    logic                   i_last;
    logic                   i_mode;
    logic [`DPE_WORD_W-1:0] i_dataa;
    logic [`DPE_WORD_W-1:0] i_datab;
    logic                   o_valid;
    logic [`DPE_ACC_W-1:0]  o_result;

    row_t        stim_q [$];
    // expected totals and the cycle each should show up in
    acc_t        exp_val_q [$];
    int unsigned exp_cyc_q [$];
    logic [31:0] model_acc;
    int unsigned cyc = 0;
    int          seed;
    int          n_expected = 0;
    int          n_seen = 0;
    int          n_value_err = 0;
    int          n_latency_err = 0;
    int          n_other_err = 0;

    dpe_top DUT (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_valid),
        .i_last   (i_last),
        .i_mode   (i_mode),
        .i_dataa  (i_dataa),
        .i_datab  (i_datab),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // rising edge count, read on falling edges only
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // one lane operand, sign-extended to 32 bits
    // int16 uses halfwords 0 and 1, lanes 2 and 3 are zero
    function automatic logic [31:0] lane_operand(input logic [31:0] w, input logic mode,
                                                 input int lane);
        if (mode == 1'b0) begin
            return {{24{w[8*lane+7]}}, w[8*lane +: 8]};
        end else if (lane < 2) begin
            return {{16{w[16*lane+15]}}, w[16*lane +: 16]};
        end
        return 32'h0;
    endfunction

    // sum of four lane products, mod 2^32
    function automatic logic [31:0] beat_sum(input logic mode, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [31:0] sum;
        sum = 32'h0;
        for (int k = 0; k < 4; k++) begin
            sum = sum + lane_operand(a, mode, k) * lane_operand(b, mode, k);
        end
        return sum;
    endfunction

    task automatic check_result(input acc_t got, input acc_t exp);
        if (got !== exp) begin
            n_value_err = n_value_err + 1;
            $display("Fail at time %0t: o_result = 0x%08h, expected 0x%08h", $time, got, exp);
        end
    endtask

    task automatic check_latency(input int unsigned got, input int unsigned exp);
        if (got != exp) begin
            n_latency_err = n_latency_err + 1;
            $display("Fail at time %0t: o_valid cycle = %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            n_other_err = n_other_err + 1;
            $display("At time %0t %0d results arrived but %0d were expected", $time, got, exp);
        end
    endtask

    task automatic add_row(input logic v, input logic l, input logic m,
                           input logic [31:0] a, input logic [31:0] b);
        stim_q.push_back({v, l, m, a, b});
    endtask

    // drive one cycle and advance the reference model
    task automatic drive_beat(input row_t r);
        @(negedge clk);
        i_valid = r.valid;
        i_last  = r.last;
        i_mode  = r.mode;
        i_dataa = r.dataa;
        i_datab = r.datab;
        if (r.valid) begin
            model_acc = model_acc + beat_sum(r.mode, r.dataa, r.datab);
            if (r.last) begin
                exp_val_q.push_back(acc_t'(model_acc));
                // sampled on the next rise, seen five falls later
                exp_cyc_q.push_back(cyc + 5);
                n_expected = n_expected + 1;
                model_acc  = 32'h0;
            end
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        i_valid = 1'b0;
        i_last  = 1'b0;
        i_dataa = '0;
        i_datab = '0;
    endtask

    task automatic wait_drain();
        while (exp_val_q.size() != 0) begin
            go_idle();
        end
        repeat (DRAIN_TAIL) go_idle();
    endtask

    // drops any vector in progress
    task automatic apply_reset();
        @(negedge clk);
        rst     = 1'b1;
        i_valid = 1'b0;
        i_last  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst       = 1'b0;
        model_acc = 32'h0;
        // held total is cleared by reset
        check_result(acc_t'(o_result), '0);
    endtask

    task automatic build_table();
        // int8 single-beat vectors
        add_row(1'b1, 1'b1, 1'b0, 32'h01020304, 32'h05060708);
        add_row(1'b1, 1'b1, 1'b0, 32'h80808080, 32'h80808080);
        add_row(1'b1, 1'b1, 1'b0, 32'h80808080, 32'h7f7f7f7f);
        add_row(1'b1, 1'b1, 1'b0, 32'hff7f01fe, 32'h7f81ff02);
        add_row(1'b1, 1'b1, 1'b0, 32'h00000000, 32'hdeadbeef);
        // int16 single-beat vectors
        add_row(1'b1, 1'b1, 1'b1, 32'h80008000, 32'h80008000);
        add_row(1'b1, 1'b1, 1'b1, 32'h7fff8000, 32'h7fff7fff);
        add_row(1'b1, 1'b1, 1'b1, 32'h00030004, 32'hfffe0005);
        // multi-beat, modes mixed
        add_row(1'b1, 1'b0, 1'b0, 32'h01010101, 32'h02020202);
        add_row(1'b1, 1'b0, 1'b1, 32'h00100020, 32'h00300040);
        add_row(1'b1, 1'b1, 1'b0, 32'hfffefdfc, 32'h01020304);
        add_row(1'b1, 1'b0, 1'b1, 32'h12345678, 32'h9abcdef0);
        add_row(1'b1, 1'b1, 1'b1, 32'h0000ffff, 32'h0000ffff);
        // idle cycles inside a vector carry junk and a stray last
        add_row(1'b1, 1'b0, 1'b0, 32'h05050505, 32'h03030303);
        add_row(1'b0, 1'b1, 1'b1, 32'hffffffff, 32'h7fff7fff);
        add_row(1'b0, 1'b0, 1'b0, 32'h80808080, 32'h80808080);
        add_row(1'b1, 1'b0, 1'b1, 32'h00020003, 32'h00040005);
        add_row(1'b0, 1'b1, 1'b0, 32'h11111111, 32'h22222222);
        add_row(1'b1, 1'b1, 1'b0, 32'h01000000, 32'h7f000000);
        // back-to-back one-beat vectors
        add_row(1'b1, 1'b1, 1'b0, 32'h00000001, 32'h00000001);
        add_row(1'b1, 1'b1, 1'b0, 32'h00000200, 32'h00000300);
        add_row(1'b1, 1'b1, 1'b1, 32'h00000005, 32'h00000007);
        add_row(1'b1, 1'b1, 1'b0, 32'hffffffff, 32'hffffffff);
        add_row(1'b1, 1'b1, 1'b1, 32'hffff0000, 32'h00010000);
        // wrap past 2^32
        add_row(1'b1, 1'b0, 1'b1, 32'h80008000, 32'h80008000);
        add_row(1'b1, 1'b0, 1'b1, 32'h80008000, 32'h80008000);
        add_row(1'b1, 1'b0, 1'b1, 32'h80008000, 32'h80008000);
        add_row(1'b1, 1'b0, 1'b1, 32'h7fff7fff, 32'h7fff7fff);
        add_row(1'b1, 1'b1, 1'b0, 32'h80808080, 32'h80808080);
    endtask

    // results are checked on the falling edge, where outputs are settled
    always @(negedge clk) begin
        if (o_valid === 1'b1) begin
            n_seen = n_seen + 1;
            if (exp_val_q.size() == 0) begin
                n_other_err = n_other_err + 1;
                $display("At time %0t o_valid pulsed with no vector pending", $time);
            end else begin
                check_result(acc_t'(o_result), exp_val_q.pop_front());
                check_latency(cyc, exp_cyc_q.pop_front());
            end
        end
    end

    initial begin
        row_t r;
        int   rnd;
        seed      = 32'hc2b2fdf4;
        rst       = 1'b1;
        i_valid   = 1'b0;
        i_last    = 1'b0;
        i_mode    = 1'b0;
        i_dataa   = '0;
        i_datab   = '0;
        model_acc = 32'h0;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        foreach (stim_q[i]) begin
            drive_beat(stim_q[i]);
        end
        wait_drain();

        // half a vector, then reset throws it away
        drive_beat({1'b1, 1'b0, 1'b0, 32'h7f7f7f7f, 32'h7f7f7f7f});
        apply_reset();

        // random beats with gaps, about one in four is last
        for (int i = 0; i < RAND_CYCLES; i++) begin
            rnd     = $random(seed);
            r.valid = (rnd[2:0] != 3'd0);
            r.last  = (rnd[4:3] == 2'd0);
            r.mode  = rnd[5];
            r.dataa = $random(seed);
            r.datab = $random(seed);
            // close the final vector
            if (i == RAND_CYCLES - 1) begin
                r.valid = 1'b1;
                r.last  = 1'b1;
            end
            drive_beat(r);
        end
        wait_drain();
        check_count(n_seen, n_expected);

        $display("Errors: %0d value, %0d latency, %0d other",
                 n_value_err, n_latency_err, n_other_err);
        if (n_value_err + n_latency_err + n_other_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        int unsigned limit;
        #1;
        limit = (stim_q.size() + 1 + RAND_CYCLES + 2 * RESET_CYCLES
                 + 2 * DRAIN_CYCLES + 20) * PERIOD;
        #(limit);
        $display("Timeout: the run did not finish within %0d time units", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: dpe_top.f
+incdir+src
src/dpe_pkg.sv
src/dpe_stage_if.sv
src/dpe_input_stage.sv
src/dpe_mult_stage.sv
src/dpe_adder_tree.sv
src/dpe_accumulator.sv
src/dpe_top.sv
sim/dpe_props.sv
sim/dpe_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := dpe_tb
FILELIST   := dpe_top.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
